//--- ising_core.f
+incdir+logic
logic/ising_pkg.sv
logic/ising_wb_decode.sv
logic/ising_weight_mem.sv
logic/ising_spin_update.sv
logic/ising_energy.sv
logic/ising_core.sv
tests/ising_core_chk.sv
tests/ising_core_tb.sv

//--- logic/ising_cfg.svh
// ising core sizes, field widths and bus word map
`ifndef ISING_CFG_SVH
`define ISING_CFG_SVH

////////////////////////////////////////
// problem size
`define ISING_NUM_SPIN 8
`define ISING_IDX_W    3                    // spin and row index
`define ISING_BIT_J    4                    // signed coupling
`define ISING_BIT_H    4                    // signed bias
`define ISING_ROW_W    (`ISING_NUM_SPIN * `ISING_BIT_J)
`define ISING_H_W      (`ISING_NUM_SPIN * `ISING_BIT_H)
`define ISING_ENERGY_W 16
`define ISING_SWEEP_W  8

////////////////////////////////////////
// bus word map
`define ISING_WORD_W     32
`define ISING_ADR_W      4
`define ISING_ADR_J0     0                  // rows 0..7 at words 0..7
`define ISING_ADR_H      8
`define ISING_ADR_CTRL   9
`define ISING_ADR_ENERGY 10

`endif

//--- logic/ising_core.sv
// ising annealing core top: bus decode, weight storage, spin engine, energy
`include "ising_cfg.svh"

module ising_core (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    // wishbone classic slave
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`ISING_ADR_W-1:0]     wb_adr_i,
    input  logic [`ISING_WORD_W-1:0]    wb_dat_i,
    input  logic [3:0]                  wb_sel_i,   // full-word access only
    output logic [`ISING_WORD_W-1:0]    wb_dat_o,
    output logic                        wb_ack_o
);

    logic                              mem_we;
    logic [`ISING_ADR_W-1:0]           mem_addr;
    logic [`ISING_WORD_W-1:0]          mem_wdata;
    logic [`ISING_WORD_W-1:0]          mem_rdata;
    logic                              start;
    logic [`ISING_NUM_SPIN-1:0]        init_spins;
    logic [`ISING_SWEEP_W-1:0]         sweeps;
    logic [`ISING_IDX_W-1:0]           a_addr;
    logic [`ISING_IDX_W-1:0]           b_addr;
    ising_pkg::j_row_t                 a_row;
    ising_pkg::j_row_t                 b_row;
    logic [`ISING_H_W-1:0]             h_word;
    logic [`ISING_NUM_SPIN-1:0]        spins;
    logic [`ISING_SWEEP_W-1:0]         sweeps_done;
    logic                              spin_busy;
    logic                              settled;
    logic signed [`ISING_ENERGY_W-1:0] energy;
    logic                              energy_busy;
    logic                              energy_done;

    ////////////////////////////////////////
    // decode
    ising_wb_decode u_decode (
        .clk_i         (clk_i      ),
        .arst_n_i      (arst_n_i   ),
        .wb_cyc_i      (wb_cyc_i   ),
        .wb_stb_i      (wb_stb_i   ),
        .wb_we_i       (wb_we_i    ),
        .wb_adr_i      (wb_adr_i   ),
        .wb_dat_i      (wb_dat_i   ),
        .wb_dat_o      (wb_dat_o   ),
        .wb_ack_o      (wb_ack_o   ),
        .mem_we_o      (mem_we     ),
        .mem_addr_o    (mem_addr   ),
        .mem_wdata_o   (mem_wdata  ),
        .mem_rdata_i   (mem_rdata  ),
        .start_o       (start      ),
        .init_spins_o  (init_spins ),
        .sweeps_o      (sweeps     ),
        .spins_i       (spins      ),
        .sweeps_done_i (sweeps_done),
        .spin_busy_i   (spin_busy  ),
        .energy_busy_i (energy_busy),
        .energy_i      (energy     ),
        .energy_done_i (energy_done)
    );

    ising_weight_mem u_weight_mem (
        .clk_i    (clk_i    ),
        .arst_n_i (arst_n_i ),
        .we_i     (mem_we   ),
        .addr_i   (mem_addr ),
        .wdata_i  (mem_wdata),
        .rdata_o  (mem_rdata),
        .a_addr_i (a_addr   ),
        .b_addr_i (b_addr   ),
        .a_row_o  (a_row    ),
        .b_row_o  (b_row    ),
        .h_word_o (h_word   )
    );

    ////////////////////////////////////////
    // execute and result
    ising_spin_update u_spin_update (
        .clk_i         (clk_i      ),
        .arst_n_i      (arst_n_i   ),
        .start_i       (start      ),
        .init_spins_i  (init_spins ),
        .sweeps_i      (sweeps     ),
        .row_addr_o    (a_addr     ),
        .row_i         (a_row      ),
        .h_word_i      (h_word     ),
        .spins_o       (spins      ),
        .sweeps_done_o (sweeps_done),
        .busy_o        (spin_busy  ),
        .settled_o     (settled    )
    );

    ising_energy u_energy (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .start_i    (settled    ),   // energy pass follows every anneal
        .spins_i    (spins      ),
        .row_addr_o (b_addr     ),
        .row_i      (b_row      ),
        .h_word_i   (h_word     ),
        .energy_o   (energy     ),
        .busy_o     (energy_busy),
        .done_o     (energy_done)
    );

endmodule

//--- logic/ising_energy.sv
// serial energy accumulator over the settled spin vector
`include "ising_cfg.svh"

module ising_energy (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              start_i,
    input  logic [`ISING_NUM_SPIN-1:0]        spins_i,
    // weight memory port B
    output logic [`ISING_IDX_W-1:0]           row_addr_o,
    input  ising_pkg::j_row_t                 row_i,
    input  logic [`ISING_H_W-1:0]             h_word_i,
    // result
    output logic signed [`ISING_ENERGY_W-1:0] energy_o,
    output logic                              busy_o,
    output logic                              done_o
);

    logic                              issue_q;
    logic                              valid_q;    // row_i holds row acc_idx_q
    logic                              done_q;
    logic [`ISING_IDX_W-1:0]           iss_idx_q;
    logic [`ISING_IDX_W-1:0]           acc_idx_q;
    logic signed [`ISING_ENERGY_W-1:0] acc_q;
    logic signed [`ISING_ENERGY_W-1:0] term;

    assign row_addr_o = iss_idx_q;

    // 2*h_i + sum_j J_ij*s_j, diagonal included
    always_comb begin
        term = $signed(h_word_i[acc_idx_q*`ISING_BIT_H +: `ISING_BIT_H]);
        term = term + term;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            if (spins_i[j]) begin
                term = term + row_i[j];
            end else begin
                term = term - row_i[j];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_q   <= 1'b0;
            valid_q   <= 1'b0;
            done_q    <= 1'b0;
            iss_idx_q <= '0;
            acc_idx_q <= '0;
            acc_q     <= '0;
        end else begin
            done_q    <= 1'b0;
            valid_q   <= issue_q;
            acc_idx_q <= iss_idx_q;
            if (start_i) begin
                issue_q   <= 1'b1;
                iss_idx_q <= '0;
                acc_q     <= '0;
            end else if (issue_q) begin
                if (iss_idx_q == `ISING_IDX_W'(`ISING_NUM_SPIN - 1)) begin
                    issue_q   <= 1'b0;
                    iss_idx_q <= '0;
                end else begin
                    iss_idx_q <= iss_idx_q + 1'b1;
                end
            end
            if (valid_q) begin
                acc_q <= spins_i[acc_idx_q] ? acc_q - term : acc_q + term;  // E = -sum s_i*term_i
                done_q <= (acc_idx_q == `ISING_IDX_W'(`ISING_NUM_SPIN - 1));
            end
        end
    end

    assign busy_o   = issue_q | valid_q | done_q;
    assign done_o   = done_q;
    assign energy_o = acc_q;

endmodule

//--- logic/ising_pkg.sv
// ising package: coupling row type and control/status word union
`include "ising_cfg.svh"

package ising_pkg;

    typedef logic signed [`ISING_BIT_J-1:0] j_field_t;

    // field j of row i holds J_ij
    typedef j_field_t [`ISING_NUM_SPIN-1:0] j_row_t;

    // command view, taken from host writes
    typedef struct packed {
        logic [`ISING_WORD_W-`ISING_NUM_SPIN-`ISING_SWEEP_W-2:0] rsvd;
        logic                                                   start;
        logic [`ISING_SWEEP_W-1:0]                              sweeps;
        logic [`ISING_NUM_SPIN-1:0]                             init_spins;
    } ctrl_cmd_t;

    // status view, returned on host reads
    typedef struct packed {
        logic [`ISING_WORD_W-`ISING_NUM_SPIN-`ISING_SWEEP_W-3:0] rsvd;
        logic                                                   done;
        logic                                                   busy;
        logic [`ISING_SWEEP_W-1:0]                              sweeps_done;
        logic [`ISING_NUM_SPIN-1:0]                             spins;
    } ctrl_status_t;

    // one word at the CTRL address, read and written with different meaning
    typedef union packed {
        ctrl_cmd_t    cmd;
        ctrl_status_t status;
    } ctrl_word_u;

endpackage

//--- logic/ising_spin_update.sv
// in-order spin update engine, one spin per fetch/update cycle pair
`include "ising_cfg.svh"

module ising_spin_update (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        start_i,
    input  logic [`ISING_NUM_SPIN-1:0]  init_spins_i,
    input  logic [`ISING_SWEEP_W-1:0]   sweeps_i,
    // weight memory port A
    output logic [`ISING_IDX_W-1:0]     row_addr_o,
    input  ising_pkg::j_row_t           row_i,
    input  logic [`ISING_H_W-1:0]       h_word_i,
    // results
    output logic [`ISING_NUM_SPIN-1:0]  spins_o,
    output logic [`ISING_SWEEP_W-1:0]   sweeps_done_o,
    output logic                        busy_o,
    output logic                        settled_o
);

    logic                              run_q;
    logic                              upd_q;      // 0 fetch row, 1 update spin
    logic [`ISING_IDX_W-1:0]           idx_q;
    logic [`ISING_NUM_SPIN-1:0]        spins_q;
    logic [`ISING_SWEEP_W-1:0]         sweeps_q;
    logic [`ISING_SWEEP_W-1:0]         done_cnt_q;
    logic                              settled_q;
    logic                              last_spin;
    logic                              last_sweep;
    logic signed [`ISING_ENERGY_W-1:0] field;

    assign row_addr_o = idx_q;

    // local field of spin idx against the current configuration
    always_comb begin
        field = $signed(h_word_i[idx_q*`ISING_BIT_H +: `ISING_BIT_H]);
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            if (spins_q[j]) begin
                field = field + row_i[j];
            end else begin
                field = field - row_i[j];
            end
        end
    end

    assign last_spin  = (idx_q == `ISING_IDX_W'(`ISING_NUM_SPIN - 1));
    assign last_sweep = (done_cnt_q + 1'b1 == sweeps_q);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q      <= 1'b0;
            upd_q      <= 1'b0;
            idx_q      <= '0;
            spins_q    <= '0;
            sweeps_q   <= '0;
            done_cnt_q <= '0;
            settled_q  <= 1'b0;
        end else begin
            settled_q <= 1'b0;
            if (start_i) begin
                spins_q    <= init_spins_i;
                sweeps_q   <= sweeps_i;
                done_cnt_q <= '0;
                idx_q      <= '0;
                upd_q      <= 1'b0;
                run_q      <= (sweeps_i != '0);
                settled_q  <= (sweeps_i == '0);  // nothing to do
            end else if (run_q) begin
                upd_q <= ~upd_q;
                if (upd_q) begin
                    if (field > 0) begin
                        spins_q[idx_q] <= 1'b1;
                    end else if (field < 0) begin
                        spins_q[idx_q] <= 1'b0;
                    end                         // zero field keeps the spin
                    idx_q <= last_spin ? '0 : idx_q + 1'b1;
                    if (last_spin) begin
                        done_cnt_q <= done_cnt_q + 1'b1;
                        if (last_sweep) begin
                            run_q     <= 1'b0;
                            settled_q <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // busy covers the settled cycle so the energy pass follows without a gap
    assign busy_o        = run_q | settled_q;
    assign settled_o     = settled_q;
    assign spins_o       = spins_q;
    assign sweeps_done_o = done_cnt_q;

endmodule

//--- logic/ising_wb_decode.sv
// Wishbone classic slave, address decode, control/status and read-back mux
`include "ising_cfg.svh"

module ising_wb_decode (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    // wishbone classic slave
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [`ISING_ADR_W-1:0]          wb_adr_i,
    input  logic [`ISING_WORD_W-1:0]         wb_dat_i,
    output logic [`ISING_WORD_W-1:0]         wb_dat_o,
    output logic                             wb_ack_o,
    // weight memory
    output logic                             mem_we_o,
    output logic [`ISING_ADR_W-1:0]          mem_addr_o,
    output logic [`ISING_WORD_W-1:0]         mem_wdata_o,
    input  logic [`ISING_WORD_W-1:0]         mem_rdata_i,
    // spin engine
    output logic                             start_o,
    output logic [`ISING_NUM_SPIN-1:0]       init_spins_o,
    output logic [`ISING_SWEEP_W-1:0]        sweeps_o,
    input  logic [`ISING_NUM_SPIN-1:0]       spins_i,
    input  logic [`ISING_SWEEP_W-1:0]        sweeps_done_i,
    input  logic                             spin_busy_i,
    // energy block
    input  logic                             energy_busy_i,
    input  logic signed [`ISING_ENERGY_W-1:0] energy_i,
    input  logic                             energy_done_i
);

    logic                              req;
    logic                              ack_q;
    logic                              wr_fire;
    logic                              busy;
    logic                              done_q;
    logic signed [`ISING_ENERGY_W-1:0] energy_q;
    ising_pkg::ctrl_word_u             cmd;
    ising_pkg::ctrl_word_u             stat;

    ////////////////////////////////////////
    // classic handshake
    assign req = wb_cyc_i & wb_stb_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req & ~ack_q;          // one-cycle ack, then re-arm
        end
    end

    assign wb_ack_o = ack_q;
    assign wr_fire  = ack_q & req & wb_we_i; // writes act in the ack cycle
    assign busy     = spin_busy_i | energy_busy_i;

    ////////////////////////////////////////
    // write side
    assign cmd = wb_dat_i;

    // J and h are locked while an anneal or energy pass runs
    assign mem_we_o    = wr_fire & ~busy & (wb_adr_i != `ISING_ADR_CTRL)
                         & (wb_adr_i != `ISING_ADR_ENERGY);
    assign mem_addr_o  = wb_adr_i;
    assign mem_wdata_o = wb_dat_i;

    assign start_o      = wr_fire & ~busy & (wb_adr_i == `ISING_ADR_CTRL) & cmd.cmd.start;
    assign init_spins_o = cmd.cmd.init_spins;
    assign sweeps_o     = cmd.cmd.sweeps;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q   <= 1'b0;
            energy_q <= '0;
        end else begin
            if (start_o) begin
                done_q <= 1'b0;
            end else if (energy_done_i) begin
                done_q <= 1'b1;
            end
            if (energy_done_i) begin
                energy_q <= energy_i;       // hold result for the host
            end
        end
    end

    ////////////////////////////////////////
    // read side
    always_comb begin
        stat                    = '0;
        stat.status.spins       = spins_i;
        stat.status.sweeps_done = sweeps_done_i;
        stat.status.busy        = busy;
        stat.status.done        = done_q;
    end

    always_comb begin
        case (wb_adr_i)
            `ISING_ADR_CTRL:   wb_dat_o = stat;
            `ISING_ADR_ENERGY: wb_dat_o = `ISING_WORD_W'(energy_q); // sign extended
            default:           wb_dat_o = mem_rdata_i; // J, h or zero
        endcase
    end

endmodule

//--- logic/ising_weight_mem.sv
// J row registers and packed h word with one bus port and two engine read ports
`include "ising_cfg.svh"

module ising_weight_mem (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    // bus port
    input  logic                        we_i,
    input  logic [`ISING_ADR_W-1:0]     addr_i,
    input  logic [`ISING_WORD_W-1:0]    wdata_i,
    output logic [`ISING_WORD_W-1:0]    rdata_o,
    // engine ports
    input  logic [`ISING_IDX_W-1:0]     a_addr_i,
    input  logic [`ISING_IDX_W-1:0]     b_addr_i,
    output ising_pkg::j_row_t           a_row_o,
    output ising_pkg::j_row_t           b_row_o,
    output logic [`ISING_H_W-1:0]       h_word_o
);

    ising_pkg::j_row_t              rows_q [`ISING_NUM_SPIN];
    logic [`ISING_H_W-1:0]          h_q;
    logic [`ISING_ADR_W-1:0]        row_off;
    logic [`ISING_IDX_W-1:0]        row_sel;
    logic                           is_row;
    logic                           is_h;

    // bus address to row index
    assign row_off = addr_i - `ISING_ADR_W'(`ISING_ADR_J0);
    assign row_sel = row_off[`ISING_IDX_W-1:0];
    assign is_row  = (row_off < `ISING_NUM_SPIN);
    assign is_h    = (addr_i == `ISING_ADR_H);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
                rows_q[i] <= '0;
            end
            h_q <= '0;
        end else if (we_i) begin
            if (is_row) begin
                rows_q[row_sel] <= wdata_i;
            end else if (is_h) begin
                h_q <= wdata_i;
            end
        end
    end

    // host read-back, unmapped words give zero
    always_comb begin
        if (is_row) begin
            rdata_o = rows_q[row_sel];
        end else if (is_h) begin
            rdata_o = h_q;
        end else begin
            rdata_o = '0;
        end
    end

    ////////////////////////////////////////
    // engine reads, one cycle latency
    always_ff @(posedge clk_i) begin
        a_row_o <= rows_q[a_addr_i];    // spin engine
        b_row_o <= rows_q[b_addr_i];    // energy block
    end

    assign h_word_o = h_q;

endmodule

//--- tests/ising_core_chk.sv
// bound checker: Wishbone ack rules and status busy/done exclusion
`include "ising_cfg.svh"

module ising_core_chk (
    input logic                         clk_i,
    input logic                         arst_n_i,
    input logic                         wb_cyc_i,
    input logic                         wb_stb_i,
    input logic                         wb_we_i,
    input logic [`ISING_ADR_W-1:0]      wb_adr_i,
    input logic [`ISING_WORD_W-1:0]     wb_dat_o,
    input logic                         wb_ack_o
);
    timeunit 1ns;
    timeprecision 100ps;

    ising_pkg::ctrl_word_u rd_word;
    logic                  stat_rd;

    assign rd_word = wb_dat_o;
    assign stat_rd = wb_ack_o & ~wb_we_i & (wb_adr_i == `ISING_ADR_CTRL);

    ////////////////////////////////////////
    // bus handshake
    ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))
        else $error("ack rose without cyc and stb");

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("ack held for two cycles");

    ack_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !wb_ack_o)
        else $error("ack high during reset");

    ////////////////////////////////////////
    // status word seen by the host
    busy_done_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stat_rd |-> !(rd_word.status.busy && rd_word.status.done))
        else $error("status shows busy and done together");

endmodule

bind ising_core ising_core_chk u_chk (
    .clk_i    (clk_i   ),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i ),
    .wb_adr_i (wb_adr_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
);

//--- tests/ising_core_tb.sv
// ising core testbench: clock, reset, Wishbone tasks, reference model, tests, report
`include "ising_cfg.svh"

module ising_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_LIMIT  = 16;     // cycles to wait for ack
    localparam int POLL_LIMIT = 5000;   // status reads before giving up

    logic        clk_i;
    logic        arst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;

    logic [7:0][31:0] j_rows;           // host copy of the J rows
    logic [31:0]      h_word;
    int               seed;
    int               errors;
    int               checks;
    int               tests;
    int               err_base;
    string            test_name;
    string            name_q[$];
    logic [31:0]      exp_q[$];
    logic [31:0]      act_q[$];
    string            cmp_name;
    logic [31:0]      cmp_exp;
    logic [31:0]      cmp_act;

    ising_core u_ising_core (
        .clk_i    (clk_i   ),
        .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i ),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // compare process, drains queued results at each rising edge
    always @(posedge clk_i) begin
        while (exp_q.size() > 0) begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            checks++;
            assert (cmp_exp === cmp_act) else begin
                $display("FAIL %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
                errors++;
            end
        end
    end

    ////////////////////////////////////////
    // reference model
    function automatic int nib(input logic [31:0] w, input int k);
        int v;
        v = w[k*4 +: 4];
        if (v >= 8) v = v - 16;         // signed 4-bit field
        return v;
    endfunction

    function automatic int sig(input logic [7:0] s, input int k);
        return s[k] ? 1 : -1;
    endfunction

    function automatic void ref_anneal(input logic [7:0][31:0] rows, input logic [31:0] h,
                                       input logic [7:0] init, input int sweeps,
                                       output logic [7:0] spins, output int energy);
        int f;
        int t;
        spins = init;
        for (int s = 0; s < sweeps; s++) begin
            for (int i = 0; i < 8; i++) begin
                f = nib(h, i);
                for (int j = 0; j < 8; j++) f += nib(rows[i], j) * sig(spins, j);
                if (f > 0) spins[i] = 1'b1;
                else if (f < 0) spins[i] = 1'b0;
            end
        end
        energy = 0;
        for (int i = 0; i < 8; i++) begin
            t = 2 * nib(h, i);
            for (int j = 0; j < 8; j++) t += nib(rows[i], j) * sig(spins, j);
            energy -= sig(spins, i) * t;
        end
    endfunction

    ////////////////////////////////////////
    // bookkeeping
    function automatic void push_check(input string name, input logic [31:0] exp,
                                       input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        err_base  = errors;
        tests++;
    endtask

    task automatic end_test();
        @(posedge clk_i);               // compare process drains here
        @(negedge clk_i);
        if (errors == err_base) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, errors - err_base);
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in test %s: %s", test_name, what);
        errors++;
        finish_run();
    endtask

    ////////////////////////////////////////
    // Wishbone classic master, drives on the falling edge
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat);
        int cnt;
        rdat = '0;
        cnt  = 0;
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        do begin
            @(negedge clk_i);
            cnt++;
        end while (!wb_ack_o && cnt < ACK_LIMIT);
        if (!wb_ack_o) begin
            report_timeout($sformatf("no ack for access to word %0d", adr));
        end else begin
            rdat = wb_dat_o;
            @(negedge clk_i);           // hold the request through the ack edge
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    ////////////////////////////////////////
    // anneal helpers
    task automatic randomize_weights();
        for (int i = 0; i < 8; i++) j_rows[i] = $random(seed);
        h_word = $random(seed);
    endtask

    task automatic load_weights();
        for (int i = 0; i < 8; i++) wb_write(`ISING_ADR_J0 + i, j_rows[i]);
        wb_write(`ISING_ADR_H, h_word);
    endtask

    task automatic start_anneal(input logic [7:0] init, input logic [7:0] sweeps);
        wb_write(`ISING_ADR_CTRL, {15'b0, 1'b1, sweeps, init});
    endtask

    task automatic wait_done(output logic [31:0] stat);
        int polls;
        polls = 0;
        stat  = '0;
        while (!stat[17] && polls < POLL_LIMIT) begin
            wb_read(`ISING_ADR_CTRL, stat);
            polls++;
        end
        if (!stat[17]) report_timeout("done bit never set in status");
    endtask

    task automatic collect_and_check(input string name, input logic [7:0] init,
                                     input logic [7:0] sweeps);
        logic [31:0] stat;
        logic [31:0] en;
        logic [7:0]  exp_spins;
        int          exp_e;
        wait_done(stat);
        wb_read(`ISING_ADR_ENERGY, en);
        ref_anneal(j_rows, h_word, init, sweeps, exp_spins, exp_e);
        push_check({name, " status"}, {14'b0, 1'b1, 1'b0, sweeps, exp_spins}, stat);
        push_check({name, " energy"}, exp_e, en);
    endtask

    ////////////////////////////////////////
    // test sequence
    initial begin
        logic [31:0] rd;
        logic [7:0]  init;
        logic [7:0]  sw;
        seed     = 32'hb6de;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        arst_n_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = 4'hf;
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;

        begin_test("reset state");
        wb_read(`ISING_ADR_CTRL, rd);
        push_check("reset status", 32'h0, rd);
        wb_read(`ISING_ADR_ENERGY, rd);
        push_check("reset energy", 32'h0, rd);
        end_test();

        begin_test("storage read-back");
        randomize_weights();
        load_weights();
        for (int i = 0; i < 8; i++) begin
            wb_read(`ISING_ADR_J0 + i, rd);
            push_check($sformatf("row %0d", i), j_rows[i], rd);
        end
        wb_read(`ISING_ADR_H, rd);
        push_check("h word", h_word, rd);
        wb_read(4'd11, rd);
        push_check("unmapped word", 32'h0, rd);
        end_test();

        begin_test("directed anneal");
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) j_rows[i][j*4 +: 4] = (i == j) ? 4'd0 : 4'd2;
        end
        h_word = '0;                    // pure ferromagnet
        load_weights();
        start_anneal(8'b1011_0010, 8'd1);
        collect_and_check("directed", 8'b1011_0010, 8'd1);
        end_test();

        for (int k = 0; k < 8; k++) begin
            begin_test($sformatf("random anneal %0d", k));
            randomize_weights();
            init = $random(seed);
            sw   = 8'd1 + ($random(seed) & 3);
            load_weights();
            start_anneal(init, sw);
            collect_and_check(test_name, init, sw);
            end_test();
        end

        begin_test("zero sweeps");
        randomize_weights();
        init = $random(seed);
        load_weights();
        start_anneal(init, 8'd0);
        collect_and_check("zero sweeps", init, 8'd0);
        end_test();

        begin_test("busy protection");
        randomize_weights();
        init = $random(seed);
        load_weights();
        start_anneal(init, 8'd200);     // long run, busy for thousands of cycles
        wb_read(`ISING_ADR_CTRL, rd);
        push_check("busy flag", 32'h1, {31'b0, rd[16]});
        wb_write(`ISING_ADR_J0 + 3, ~j_rows[3]);
        start_anneal(~init, 8'd1);      // must be ignored
        collect_and_check("busy protection", init, 8'd200);
        wb_read(`ISING_ADR_J0 + 3, rd);
        push_check("row 3 after busy write", j_rows[3], rd);
        end_test();

        finish_run();
    end

endmodule
